// ==== include/led_spi_settings.svh ====
////////////////////////////////////////////////////////////
// compile-time sizes for the SPI LED peripheral
// include wherever LED count, frame width or blink rate
// is needed; the package carries the types
////////////////////////////////////////////////////////////

`ifndef LED_SPI_SETTINGS_SVH
`define LED_SPI_SETTINGS_SVH

// number of LEDs, also the width of the frame data field
`define LED_COUNT 4

// bits per SPI command frame, msb first
`define FRAME_BITS 8

// log2 of clk cycles per blink step
// 4 keeps simulation short, a board wants about 20
`define BLINK_LOG2DELAY 4

`endif

// ==== project.f ====
+incdir+include
rtl/led_spi_pkg.sv
rtl/spi_frame_rx.sv
rtl/blink_timer.sv
rtl/led_mux.sv
rtl/led_spi_top.sv
tests/tb_clock_gen.sv
tests/led_spi_props.sv
tests/tb_led_spi.sv

// ==== rtl/blink_timer.sv ====
////////////////////////////////////////////////////////////
// free-running blink divider with a Gray-coded pattern
// step pulses once per 2**BLINK_LOG2DELAY cycles and gray
// moves one Gray step on that same edge
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "led_spi_settings.svh"

module blink_timer
(
  input  logic                   clk,
  input  logic                   rst_n,
  output logic [`LED_COUNT-1:0]  gray,
  output logic                   step
);

  logic [`BLINK_LOG2DELAY-1:0]  div_q;
  logic [`LED_COUNT-1:0]        count_q;
  logic [`LED_COUNT-1:0]        count_next;
  logic                         wrap;

  // divider about to roll over
  assign wrap = &div_q;
  assign count_next = count_q + 1'b1;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      div_q   <= '0;
      count_q <= '0;
      gray    <= '0;
      step    <= 1'b0;
    end
    else
    begin
      div_q <= div_q + 1'b1;
      step  <= wrap;
      if (wrap)
      begin
        count_q <= count_next;
        // binary to Gray, built from the next count
        // so gray and step land on the same edge
        gray    <= count_next ^ (count_next >> 1);
      end
    end
  end

endmodule

// ==== rtl/led_mux.sv ====
////////////////////////////////////////////////////////////
// holds the last accepted command and drives the LEDs
// leds are registered and only move after cmd_valid or
// step, so the outputs never glitch between events
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "led_spi_settings.svh"

module led_mux
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  led_spi_pkg::led_cmd_t  cmd,
  input  logic                   cmd_valid,
  input  logic [`LED_COUNT-1:0]  gray,
  input  logic                   step,
  output logic [`LED_COUNT-1:0]  leds
);

  led_spi_pkg::led_op_e   op_q;
  logic [`LED_COUNT-1:0]  data_q;
  led_spi_pkg::led_op_e   op_eff;
  logic [`LED_COUNT-1:0]  data_eff;

  // opcode rule, one place for every caller
  function automatic logic [`LED_COUNT-1:0] led_pattern
  (
    input led_spi_pkg::led_op_e   op,
    input logic [`LED_COUNT-1:0]  data,
    input logic [`LED_COUNT-1:0]  pat
  );
    logic [`LED_COUNT-1:0] res;
    case (op)
      led_spi_pkg::op_off:    res = '0;
      led_spi_pkg::op_static: res = data;
      led_spi_pkg::op_blink:  res = pat;
      led_spi_pkg::op_xor:    res = data ^ pat;
      default:                res = '0;
    endcase
    return res;
  endfunction

  // a fresh command wins over the held one
  // so leds follow on the very next cycle
  assign op_eff = cmd_valid ? cmd.op : op_q;
  assign data_eff = cmd_valid ? cmd.data : data_q;

  // held command
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      op_q <= led_spi_pkg::op_off;
    end
    else if (cmd_valid)
    begin
      op_q <= cmd.op;
    end
  end

  always_ff @(posedge clk)
  begin
    if (cmd_valid)
    begin
      data_q <= cmd.data;
    end
  end

  // LED register, event driven only
  // in off or static mode a step recomputes the same value
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      leds <= '0;
    end
    else if (cmd_valid || step)
    begin
      leds <= led_pattern(op_eff, data_eff, gray);
    end
  end

endmodule

// ==== rtl/led_spi_pkg.sv ====
////////////////////////////////////////////////////////////
// shared types of the SPI LED peripheral
// referenced as led_spi_pkg::name, never imported
////////////////////////////////////////////////////////////

`include "led_spi_settings.svh"

package led_spi_pkg;

  // command opcodes, top two bits of a frame
  typedef enum logic [1:0]
  {
    op_off    = 2'd0,  // all dark
    op_static = 2'd1,  // show data field
    op_blink  = 2'd2,  // show gray pattern
    op_xor    = 2'd3   // data xor gray pattern
  } led_op_e;

  // receiver FSM states
  typedef enum logic [1:0]
  {
    idle     = 2'd0,
    shifting = 2'd1,
    closing  = 2'd2
  } rx_state_e;

  // one command frame as it arrives on mosi
  // op in bits 7:6, rsvd in 5:4 (ignored), data in 3:0
  typedef struct packed
  {
    led_op_e                op;
    logic [1:0]             rsvd;
    logic [`LED_COUNT-1:0]  data;
  } led_cmd_t;

endpackage

// ==== rtl/led_spi_top.sv ====
////////////////////////////////////////////////////////////
// top of the SPI LED peripheral
// SPI receiver and blink timer run side by side and the
// LED mux merges their results; instances and wires only
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "led_spi_settings.svh"

module led_spi_top
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   sclk,
  input  logic                   cs_n,
  input  logic                   mosi,
  output logic [`LED_COUNT-1:0]  leds,
  output logic                   bad_frame
);

  // receiver to mux
  led_spi_pkg::led_cmd_t  cmd;
  logic                   cmd_valid;

  // timer to mux
  logic [`LED_COUNT-1:0]  gray;
  logic                   step;

  // SPI pins in, frame strobes out
  spi_frame_rx i_spi_frame_rx
  (
    .clk       (clk),
    .rst_n     (rst_n),
    .sclk      (sclk),
    .cs_n      (cs_n),
    .mosi      (mosi),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .bad_frame (bad_frame)
  );

  // free-running blink pattern
  blink_timer i_blink_timer
  (
    .clk   (clk),
    .rst_n (rst_n),
    .gray  (gray),
    .step  (step)
  );

  // command hold and LED drive
  led_mux i_led_mux
  (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .gray      (gray),
    .step      (step),
    .leds      (leds)
  );

endmodule

// ==== rtl/spi_frame_rx.sv ====
////////////////////////////////////////////////////////////
// oversampling SPI receiver for 8-bit command frames
// pins are asynchronous to clk; a frame is accepted only
// when exactly FRAME_BITS bits arrive while cs_n is low
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "led_spi_settings.svh"

module spi_frame_rx
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   sclk,
  input  logic                   cs_n,
  input  logic                   mosi,
  output led_spi_pkg::led_cmd_t  cmd,
  output logic                   cmd_valid,
  output logic                   bad_frame
);

  // bit counter must hold FRAME_BITS + 1 to see overlong frames
  localparam int CNT_W = $clog2(`FRAME_BITS + 2);
  localparam logic [CNT_W-1:0] CNT_FRAME = CNT_W'(`FRAME_BITS);
  localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(`FRAME_BITS + 1);

  // lane index into the control pin vectors
  localparam int SCLK_BIT = 0;
  localparam int CS_BIT = 1;

  // idle levels: sclk low, cs_n high
  localparam logic [1:0] PIN_IDLE = 2'b10;

  logic [1:0]              pin_s1;
  logic [1:0]              pin_s2;
  logic [1:0]              pin_s3;
  logic [1:0]              rise_q;
  logic                    cs_fall_q;
  logic                    mosi_s1;
  logic                    mosi_s2;
  logic                    mosi_s3;
  logic                    sclk_rise;
  logic                    cs_rise;
  logic [`FRAME_BITS-1:0]  shift_q;
  logic [CNT_W-1:0]        cnt_q;
  led_spi_pkg::rx_state_e  state_q;

  // two sync flops, then the edge-detect register
  // sclk and cs_n share one vector so both lanes see equal delay
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      pin_s1    <= PIN_IDLE;
      pin_s2    <= PIN_IDLE;
      pin_s3    <= PIN_IDLE;
      rise_q    <= 2'b00;
      cs_fall_q <= 1'b0;
    end
    else
    begin
      pin_s1    <= {cs_n, sclk};
      pin_s2    <= pin_s1;
      pin_s3    <= pin_s2;
      // registered edge pulses, one cycle wide
      rise_q    <= pin_s2 & ~pin_s3;
      cs_fall_q <= ~pin_s2[CS_BIT] & pin_s3[CS_BIT];
    end
  end

  // mosi follows the same three stages
  // so mosi_s3 lines up with the registered sclk rise
  always_ff @(posedge clk)
  begin
    mosi_s1 <= mosi;
    mosi_s2 <= mosi_s1;
    mosi_s3 <= mosi_s2;
  end

  assign sclk_rise = rise_q[SCLK_BIT];
  assign cs_rise = rise_q[CS_BIT];

  // frame FSM and bit counter
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_q <= led_spi_pkg::idle;
      cnt_q   <= '0;
    end
    else
    begin
      case (state_q)
        led_spi_pkg::idle:
        begin
          // cs_n fall opens a frame
          if (cs_fall_q)
          begin
            state_q <= led_spi_pkg::shifting;
            cnt_q   <= '0;
          end
        end
        led_spi_pkg::shifting:
        begin
          // count saturates one above a full frame
          if (sclk_rise && (cnt_q != CNT_MAX))
          begin
            cnt_q <= cnt_q + 1'b1;
          end
          if (cs_rise)
          begin
            state_q <= led_spi_pkg::closing;
          end
        end
        led_spi_pkg::closing:
        begin
          // one cycle for the verdict strobe
          // a very short cs_n high can already start the next frame
          if (cs_fall_q)
          begin
            state_q <= led_spi_pkg::shifting;
            cnt_q   <= '0;
          end
          else
          begin
            state_q <= led_spi_pkg::idle;
          end
        end
        default:
        begin
          state_q <= led_spi_pkg::idle;
        end
      endcase
    end
  end

  // shift register, msb first
  always_ff @(posedge clk)
  begin
    if ((state_q == led_spi_pkg::shifting) && sclk_rise)
    begin
      shift_q <= {shift_q[`FRAME_BITS-2:0], mosi_s3};
    end
  end

  assign cmd = led_spi_pkg::led_cmd_t'(shift_q);

  // exactly one strobe per closed frame
  // zero-bit frames fall into bad_frame too
  assign cmd_valid = (state_q == led_spi_pkg::closing) && (cnt_q == CNT_FRAME);
  assign bad_frame = (state_q == led_spi_pkg::closing) && (cnt_q != CNT_FRAME);

endmodule

// ==== tests/led_spi_props.sv ====
////////////////////////////////////////////////////////////
// concurrent assertions on the frame strobes and LED drive
// bound into the top level, sees the internal strobe wires
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "led_spi_settings.svh"

module led_spi_props
(
  input logic                   clk,
  input logic                   rst_n,
  input logic                   cmd_valid,
  input logic                   bad_frame,
  input logic                   step,
  input logic [`LED_COUNT-1:0]  leds
);

  // running count of assertion failures
  int fail_cnt = 0;

  // one verdict per closed frame
  strobes_exclusive: assert property
    (@(posedge clk) disable iff (!rst_n) !(cmd_valid && bad_frame))
    else
    begin
      fail_cnt++;
      $error("cmd_valid and bad_frame high in the same cycle");
    end

  // strobes are single-cycle
  cmd_valid_single: assert property
    (@(posedge clk) disable iff (!rst_n) cmd_valid |=> !cmd_valid)
    else
    begin
      fail_cnt++;
      $error("cmd_valid held for more than one cycle");
    end

  bad_frame_single: assert property
    (@(posedge clk) disable iff (!rst_n) bad_frame |=> !bad_frame)
    else
    begin
      fail_cnt++;
      $error("bad_frame held for more than one cycle");
    end

  // leds move only after a command or a blink step
  leds_event_only: assert property
    (@(posedge clk) disable iff (!rst_n)
      (leds != $past(leds)) |-> ($past(cmd_valid) || $past(step)))
    else
    begin
      fail_cnt++;
      $error("leds changed without cmd_valid or step");
    end

endmodule

bind led_spi_top led_spi_props i_led_spi_props
(
  .clk       (clk),
  .rst_n     (rst_n),
  .cmd_valid (cmd_valid),
  .bad_frame (bad_frame),
  .step      (step),
  .leds      (leds)
);

// ==== tests/tb_clock_gen.sv ====
////////////////////////////////////////////////////////////
// testbench clock and reset source
// 4 ns clk, rst_n held low for the first two rising edges
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_clock_gen
(
  output logic clk,
  output logic rst_n
);

  // free-running clock, 2 ns per phase
  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // synchronous reset, released after two edges
  initial
  begin
    rst_n = 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

// ==== tests/tb_led_spi.sv ====
////////////////////////////////////////////////////////////
// testbench for the SPI LED peripheral
// random frames from an xorshift source, a command model,
// Gray-step checks in blink and xor modes, then a verdict
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "led_spi_settings.svh"

module tb_led_spi;

  localparam int NUM_FRAMES = 200;
  localparam int MIN_HALF = 3;
  localparam int MAX_HALF = 6;
  localparam int MAX_BITS = 11;
  localparam int SETTLE = 8;
  localparam int OBS_CYCLES = 40;
  // longest frame: cs setup, bits, cs hold, settle, observe
  localparam int FRAME_CYCLES = MAX_HALF * (2 * MAX_BITS + 2) + SETTLE + OBS_CYCLES;
  localparam int TIMEOUT = NUM_FRAMES * FRAME_CYCLES + 500;

  logic                   clk;
  logic                   rst_n;
  logic                   sclk;
  logic                   cs_n;
  logic                   mosi;
  logic [`LED_COUNT-1:0]  leds;
  logic                   bad_frame;

  logic [31:0]            rng_state = 32'd75;
  int                     errors = 0;
  int                     checks = 0;
  int                     bad_seen = 0;
  int                     bad_expected = 0;
  int                     cycle_cnt = 0;
  // model of the held command
  logic [1:0]             exp_op = 2'd0;
  logic [`LED_COUNT-1:0]  exp_data = '0;

  tb_clock_gen i_tb_clock_gen
  (
    .clk   (clk),
    .rst_n (rst_n)
  );

  led_spi_top i_led_spi_top
  (
    .clk       (clk),
    .rst_n     (rst_n),
    .sclk      (sclk),
    .cs_n      (cs_n),
    .mosi      (mosi),
    .leds      (leds),
    .bad_frame (bad_frame)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // uniform draw in lo..hi
  task automatic draw(input int lo, input int hi, output int val);
    rng_state = xorshift32(rng_state);
    val = lo + int'(rng_state % (hi - lo + 1));
  endtask

  // next code in the reflected Gray sequence
  function automatic logic [`LED_COUNT-1:0] gray_next(input logic [`LED_COUNT-1:0] g);
    logic [`LED_COUNT-1:0] b;
    b[`LED_COUNT-1] = g[`LED_COUNT-1];
    for (int i = `LED_COUNT - 2; i >= 0; i--)
    begin
      b[i] = b[i + 1] ^ g[i];
    end
    b = b + 1'b1;
    return b ^ (b >> 1);
  endfunction

  task automatic report_mismatch(input string name, input int expected, input int actual);
    errors++;
    $display("CHECK FAILED %s: expected 'h%0h, actual 'h%0h at %0t",
             name, expected, actual, $time);
  endtask

  // one SPI frame, msb first, driven on rising clk
  task automatic send_frame(input logic [15:0] word, input int nbits, input int half);
    @(posedge clk);
    cs_n <= 1'b0;
    repeat (half) @(posedge clk);
    for (int i = nbits - 1; i >= 0; i--)
    begin
      // mosi settles a half period before the rising sclk
      mosi <= word[i];
      repeat (half) @(posedge clk);
      sclk <= 1'b1;
      repeat (half) @(posedge clk);
      sclk <= 1'b0;
    end
    repeat (half) @(posedge clk);
    cs_n <= 1'b1;
  endtask

  // watch leds for a while under the held command
  task automatic observe_leds();
    logic [`LED_COUNT-1:0] mask;
    logic [`LED_COUNT-1:0] prev;
    logic [`LED_COUNT-1:0] cur;
    logic [`LED_COUNT-1:0] fixed;
    int changes;
    changes = 0;
    if (exp_op == 2'd0 || exp_op == 2'd1)
    begin
      // off is dark, static shows data, across several steps
      fixed = (exp_op == 2'd1) ? exp_data : '0;
      for (int c = 0; c < OBS_CYCLES; c++)
      begin
        @(negedge clk);
        checks++;
        if (leds !== fixed)
        begin
          report_mismatch((exp_op == 2'd1) ? "static_leds" : "off_leds", fixed, leds);
        end
      end
    end
    else
    begin
      // strip the data in xor mode, leaving the bare pattern
      mask = (exp_op == 2'd3) ? exp_data : '0;
      prev = leds ^ mask;
      for (int c = 0; c < OBS_CYCLES; c++)
      begin
        @(negedge clk);
        cur = leds ^ mask;
        if (cur !== prev)
        begin
          changes++;
          checks++;
          if (cur !== gray_next(prev))
          begin
            report_mismatch((exp_op == 2'd3) ? "xor_gray_step" : "blink_gray_step",
                            gray_next(prev), cur);
          end
          prev = cur;
        end
      end
      // step every 16 cycles, so 40 cycles see at least two
      checks++;
      if (changes < 2)
      begin
        report_mismatch("pattern_activity", 2, changes);
      end
    end
  endtask

  // bad_frame pulses, sampled mid-cycle
  always @(negedge clk)
  begin
    if (rst_n && (bad_frame === 1'b1))
    begin
      bad_seen++;
    end
  end

  // run limit
  always @(posedge clk)
  begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT)
    begin
      $display("timeout: the run did not finish within %0d clk cycles", TIMEOUT);
      $display("*** FAILED ***");
      $finish;
    end
  end

  initial
  begin
    int r;
    int half;
    int nbits;
    int sel;
    int assert_fails;
    logic [15:0] word;
    sclk = 1'b0;
    cs_n = 1'b1;
    mosi = 1'b0;
    wait (rst_n === 1'b1);
    repeat (20) @(negedge clk);

    // quiet after reset
    checks++;
    if (leds !== '0)
    begin
      report_mismatch("reset_leds", 0, leds);
    end
    checks++;
    if (bad_seen != 0)
    begin
      report_mismatch("reset_bad_frame", 0, bad_seen);
    end

    for (int f = 0; f < NUM_FRAMES; f++)
    begin
      draw(0, 65535, r);
      word = r[15:0];
      draw(MIN_HALF, MAX_HALF, half);
      // about one frame in five has a wrong length
      draw(0, 4, sel);
      nbits = `FRAME_BITS;
      if (sel == 0)
      begin
        draw(0, 5, r);
        nbits = (r < 3) ? 5 + r : 6 + r;
      end
      send_frame(word, nbits, half);
      if (nbits == `FRAME_BITS)
      begin
        // op in bits 7:6, reserved 5:4 ignored, data in 3:0
        exp_op = word[7:6];
        exp_data = word[`LED_COUNT-1:0];
      end
      else
      begin
        bad_expected++;
      end
      repeat (SETTLE) @(negedge clk);
      checks++;
      if (bad_seen != bad_expected)
      begin
        report_mismatch("bad_frame_count", bad_expected, bad_seen);
      end
      observe_leds();
    end

    // bound property failures count against the run as well
    assert_fails = i_led_spi_top.i_led_spi_props.fail_cnt;
    $display("checks: %0d  errors: %0d  assertion errors: %0d  bad frames: %0d seen, %0d sent",
             checks, errors, assert_fails, bad_seen, bad_expected);
    if ((errors == 0) && (assert_fails == 0))
    begin
      $display("*** PASSED ***");
    end
    else
    begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
